/* filelist.f */
hw/bpred_pkg.sv
hw/ir_classifier.sv
hw/sweep_counter.sv
hw/clear_sequencer.sv
hw/pred_table.sv
hw/jump_predictor_top.sv
verification/tb_jump_predictor.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_jump_predictor
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_jump_predictor.sv */
module tb_jump_predictor import bpred_pkg::*; ();

    localparam int TABLE_SIZE = 32;
    localparam int NUM_BITS   = 5;

    // Index bits of a PC
    localparam logic [31:0] INDEX_MASK = 32'((TABLE_SIZE - 1) << 2);

    // Run limit is twice the summed test lengths in cycles
    localparam int LEN_CLEAR   = 40;
    localparam int LEN_CLASS   = 40;
    localparam int LEN_TRAIN   = 20;
    localparam int LEN_ALIAS   = 5;
    localparam int LEN_FLUSH   = 120;
    localparam int LEN_RANDOM  = 400;
    localparam int CYCLE_LIMIT = 2 * (LEN_CLEAR + LEN_CLASS + LEN_TRAIN + LEN_ALIAS
                                      + LEN_FLUSH + LEN_RANDOM);

    logic        clk = 1'b0;
    logic        reset;
    fetch_t      fetch_in;
    resolve_t    resolve_in;
    logic        flush_in;
    logic        pred_taken;
    logic [31:0] pred_addr;
    logic        ready;

    // Reference model state
    ctr_state_t          model_ctr [TABLE_SIZE];
    logic [31:0]         model_tgt [TABLE_SIZE];
    int                  clear_left = TABLE_SIZE;
    logic [NUM_BITS-1:0] sweep_slot;
    logic [NUM_BITS-1:0] rd_slot;
    logic [NUM_BITS-1:0] wr_slot;
    ir_type_t            fetch_type;
    logic                exp_taken;
    logic [31:0]         exp_addr;
    logic                exp_ready;

    string test_name = "reset";
    int    mismatch_count = 0;
    int    error_count = 0;
    int    test_fail_base = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycle_count = 0;

    jump_predictor_top #(
        .TABLE_SIZE (TABLE_SIZE),
        .NUM_BITS   (NUM_BITS)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .fetch      (fetch_in),
        .resolve    (resolve_in),
        .flush      (flush_in),
        .pred_taken (pred_taken),
        .pred_addr  (pred_addr),
        .ready      (ready)
    );

    always #20 clk = ~clk;

    // Branch funct3 of 010 or 011 is not a branch
    function automatic ir_type_t classify_word(input logic [31:0] w);
        ir_type_t t;
        case (w[6:0])
            7'b1101111: t = IR_JAL;
            7'b1100111: t = IR_JALR;
            7'b1100011: t = (w[14:13] == 2'b01) ? IR_OTHER : IR_BRANCH;
            default:    t = IR_OTHER;
        endcase
        return t;
    endfunction

    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic ctr_state_t counter_step(input ctr_state_t c, input logic taken);
        ctr_state_t r;
        case (c)
            STRONG_NOT_TAKE: r = taken ? WEAK_NOT_TAKE : STRONG_NOT_TAKE;
            WEAK_NOT_TAKE:   r = taken ? WEAK_TAKE : STRONG_NOT_TAKE;
            WEAK_TAKE:       r = taken ? STRONG_TAKE : WEAK_NOT_TAKE;
            default:         r = taken ? STRONG_TAKE : WEAK_TAKE;
        endcase
        return r;
    endfunction

    // JAL with rd = x1
    function automatic logic [31:0] jal_word(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] funct3);
        return {7'd0, 5'd2, 5'd1, funct3, 5'd8, 7'b1100011};
    endfunction

    function automatic logic [31:0] rand_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    // Random PC that maps to the same table entry as base
    function automatic logic [31:0] pc_in_entry(input logic [31:0] base);
        return (rand_pc() & ~INDEX_MASK) | (base & INDEX_MASK);
    endfunction

    assign sweep_slot = NUM_BITS'(TABLE_SIZE - clear_left);
    assign rd_slot    = fetch_in.pc[NUM_BITS+1:2];
    assign wr_slot    = resolve_in.pc[NUM_BITS+1:2];

    always @(posedge clk) begin
        if (reset) begin
            clear_left <= TABLE_SIZE;
        end else begin
            if (clear_left > 0) begin
                model_ctr[sweep_slot] <= WEAK_NOT_TAKE;
                model_tgt[sweep_slot] <= 32'd0;
                clear_left <= clear_left - 1;
            end else if (resolve_in.valid &&
                         (resolve_in.ir_type == IR_JALR || resolve_in.ir_type == IR_BRANCH)) begin
                model_ctr[wr_slot] <= counter_step(model_ctr[wr_slot], resolve_in.taken);
                if (resolve_in.taken) begin
                    model_tgt[wr_slot] <= resolve_in.target;
                end
            end
            // Flush restarts the sweep
            if (flush_in) begin
                clear_left <= TABLE_SIZE;
            end
        end
    end

    always_comb begin
        fetch_type = classify_word(fetch_in.instr);
        exp_ready  = (clear_left == 0);
        exp_taken  = 1'b0;
        exp_addr   = fetch_in.pc4;
        if (fetch_type == IR_JAL) begin
            exp_taken = 1'b1;
            exp_addr  = fetch_in.pc + jal_offset(fetch_in.instr);
        end else if ((fetch_type == IR_JALR || fetch_type == IR_BRANCH) && exp_ready &&
                     (model_ctr[rd_slot] == WEAK_TAKE || model_ctr[rd_slot] == STRONG_TAKE)) begin
            exp_taken = 1'b1;
            exp_addr  = model_tgt[rd_slot];
        end
    end

    ready_check: assert property (@(posedge clk) disable iff (reset) ready == exp_ready)
        else begin
            $display("MISMATCH %s ready expected %0b actual %0b",
                     test_name, $sampled(exp_ready), $sampled(ready));
            mismatch_count++;
        end

    taken_check: assert property (@(posedge clk) disable iff (reset) pred_taken == exp_taken)
        else begin
            $display("MISMATCH %s pred_taken expected %0b actual %0b",
                     test_name, $sampled(exp_taken), $sampled(pred_taken));
            mismatch_count++;
        end

    addr_check: assert property (@(posedge clk) disable iff (reset) pred_addr == exp_addr)
        else begin
            $display("MISMATCH %s pred_addr expected %08h actual %08h",
                     test_name, $sampled(exp_addr), $sampled(pred_addr));
            mismatch_count++;
        end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic step();
        @(negedge clk);
    endtask

    task automatic set_fetch(input logic [31:0] pc, input logic [31:0] word);
        fetch_in.pc    = pc;
        fetch_in.pc4   = pc + 32'd4;
        fetch_in.instr = word;
    endtask

    task automatic train(input logic [31:0] pc, input ir_type_t ty, input logic taken,
                         input logic [31:0] target);
        resolve_in.valid   = 1'b1;
        resolve_in.pc      = pc;
        resolve_in.ir_type = ty;
        resolve_in.taken   = taken;
        resolve_in.target  = target;
        step();
        resolve_in = '0;
    endtask

    task automatic pulse_flush();
        flush_in = 1'b1;
        step();
        flush_in = 1'b0;
    endtask

    // Waits for ready while alternating a branch and a JAL fetch
    task automatic count_clear(input logic [31:0] pc);
        int n;
        n = 0;
        while (!ready && n < 4 * TABLE_SIZE) begin
            if ((n % 2) == 1) begin
                set_fetch(pc, jal_word(21'h00_0100));
            end else begin
                set_fetch(pc, branch_word(3'b100));
            end
            step();
            n++;
        end
        if (!ready) begin
            $display("%s: ready did not rise within %0d cycles", test_name, n);
            error_count++;
        end else begin
            clear_length: assert (n == TABLE_SIZE)
                else begin
                    $display("MISMATCH %s clear cycles expected %0d actual %0d",
                             test_name, TABLE_SIZE, n);
                    error_count++;
                end
        end
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_fail_base = mismatch_count + error_count;
    endtask

    task automatic end_test();
        int fails;
        fails = mismatch_count + error_count - test_fail_base;
        tests_run++;
        if (fails != 0) begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", test_name, fails);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    initial begin
        logic [31:0] pc_t;
        logic [31:0] pc_a;
        logic [31:0] pc_c;
        logic [31:0] word;
        logic [31:0] r;
        int          kind;

        void'($urandom(32'ha996_d7ff));
        reset      = 1'b1;
        flush_in   = 1'b0;
        fetch_in   = '0;
        resolve_in = '0;
        pc_t       = 32'h0000_1040;
        pc_a       = 32'h0000_2008;
        pc_c       = 32'h0000_3010;
        repeat (2) step();
        reset = 1'b0;

        begin_test("clear_timing");
        count_clear(pc_t);
        end_test();

        // Entry trained taken so that a misread word would predict taken
        begin_test("classification");
        train(pc_c, IR_BRANCH, 1'b1, 32'h0000_6600);
        repeat (8) begin
            set_fetch(pc_in_entry(pc_c), 32'h0010_0093);
            step();
            set_fetch(pc_in_entry(pc_c), branch_word(3'b010));
            step();
            set_fetch(pc_in_entry(pc_c), branch_word(3'b011));
            step();
            set_fetch(rand_pc(), jal_word(21'($urandom)));
            step();
        end
        end_test();

        // Taken, two not taken, saturate, then one not taken
        begin_test("counter_training");
        set_fetch(pc_t, branch_word(3'b000));
        train(pc_t, IR_BRANCH, 1'b1, 32'h0000_2000);
        step();
        train(pc_t, IR_BRANCH, 1'b0, 32'h0000_0000);
        train(pc_t, IR_BRANCH, 1'b0, 32'h0000_0000);
        step();
        repeat (4) train(pc_t, IR_BRANCH, 1'b1, 32'h0000_3000);
        train(pc_t, IR_BRANCH, 1'b0, 32'h0000_5000);
        step();
        end_test();

        // PCs 128 bytes apart share one entry
        begin_test("aliasing");
        set_fetch(pc_a + 32'd128, branch_word(3'b001));
        step();
        train(pc_a, IR_JALR, 1'b1, 32'h0000_7700);
        step();
        end_test();

        begin_test("flush");
        set_fetch(pc_t, branch_word(3'b101));
        step();
        pulse_flush();
        count_clear(pc_t);
        set_fetch(pc_t, branch_word(3'b101));
        step();
        pulse_flush();
        repeat (10) step();
        pulse_flush();
        count_clear(pc_t);
        end_test();

        // Resolves of every type, valid or not, so only qualifying ones train
        begin_test("random_mix");
        repeat (LEN_RANDOM - 20) begin
            r    = $urandom;
            kind = $urandom % 4;
            word = $urandom;
            case (kind)
                0: word[6:0] = 7'b1100011;
                1: word[6:0] = 7'b1100111;
                2: word = jal_word(21'($urandom));
                default: ;
            endcase
            resolve_in.valid   = r[0];
            resolve_in.pc      = 32'h0000_4000 + (($urandom % 96) << 2);
            resolve_in.ir_type = ir_type_t'({2'b00, r[2:1]});
            resolve_in.taken   = r[3];
            resolve_in.target  = $urandom & 32'hffff_fffc;
            set_fetch(32'h0000_4000 + (($urandom % 96) << 2), word);
            step();
        end
        resolve_in = '0;
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, mismatch_count + error_count);
        if (mismatch_count + error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* hw/jump_predictor_top.sv */
module jump_predictor_top import bpred_pkg::*; #(
    parameter int TABLE_SIZE = 32,
    parameter int NUM_BITS   = 5
) (
    input  logic        clk,
    input  logic        reset,

    // IF stage lookup
    input  fetch_t      fetch,

    // EX stage outcome
    input  resolve_t    resolve,
    input  logic        flush,

    output logic        pred_taken,
    output logic [31:0] pred_addr,
    output logic        ready
);

    ir_type_t            ir_type;
    logic [31:0]         jal_target;
    logic [NUM_BITS-1:0] rd_index;
    logic [NUM_BITS-1:0] wr_index;
    entry_t              rd_entry;
    logic                entry_taken;
    logic                clear_en;
    logic                start;
    logic                last;
    logic [NUM_BITS-1:0] clear_index;

    // Word aligned PCs, bits 1:0 carry no information
    assign rd_index = fetch.pc[NUM_BITS+1:2];
    assign wr_index = resolve.pc[NUM_BITS+1:2];

    ir_classifier u_classifier (
        .instr      (fetch.instr),
        .pc         (fetch.pc),
        .ir_type    (ir_type),
        .jal_target (jal_target)
    );

    pred_table #(
        .TABLE_SIZE (TABLE_SIZE),
        .NUM_BITS   (NUM_BITS)
    ) u_table (
        .clk         (clk),
        .reset       (reset),
        .rd_index    (rd_index),
        .rd_entry    (rd_entry),
        .wr_index    (wr_index),
        .resolve     (resolve),
        .clear_en    (clear_en),
        .clear_index (clear_index)
    );

    clear_sequencer u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .last     (last),
        .start    (start),
        .clear_en (clear_en),
        .ready    (ready)
    );

    sweep_counter #(
        .NUM_BITS (NUM_BITS)
    ) u_sweep (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .run   (clear_en),
        .index (clear_index),
        .last  (last)
    );

    // Table contents only trusted once the sweep has finished
    assign entry_taken = ready &&
                         ((rd_entry.ctr == WEAK_TAKE) || (rd_entry.ctr == STRONG_TAKE));

    always_comb begin
        pred_taken = 1'b0;
        pred_addr  = fetch.pc4;

        case (ir_type)
            // JAL target comes straight from the instruction word
            IR_JAL: begin
                pred_taken = 1'b1;
                pred_addr  = jal_target;
            end

            IR_JALR, IR_BRANCH: begin
                if (entry_taken) begin
                    pred_taken = 1'b1;
                    pred_addr  = rd_entry.target;
                end
            end

            default: begin
                pred_taken = 1'b0;
                pred_addr  = fetch.pc4;
            end
        endcase
    end

endmodule

/* hw/pred_table.sv */
module pred_table import bpred_pkg::*; #(
    parameter int TABLE_SIZE = 32,
    parameter int NUM_BITS   = 5
) (
    input  logic                clk,
    input  logic                reset,

    // Lookup port for the IF stage
    input  logic [NUM_BITS-1:0] rd_index,
    output entry_t              rd_entry,

    // Training port from the EX stage
    input  logic [NUM_BITS-1:0] wr_index,
    input  resolve_t            resolve,

    // Clear sweep
    input  logic                clear_en,
    input  logic [NUM_BITS-1:0] clear_index
);

    // Entry array, indexed by pc[NUM_BITS+1:2]
    entry_t entries [TABLE_SIZE];

    entry_t clear_entry;
    entry_t old_entry;
    entry_t new_entry;
    logic   train;

    // Saturating step of the 2-bit counter
    function automatic ctr_state_t next_ctr(input ctr_state_t cur, input logic taken);
        ctr_state_t nxt;
        if (taken) begin
            if (cur == STRONG_TAKE) begin
                nxt = STRONG_TAKE;
            end else begin
                nxt = ctr_state_t'(cur + 2'd1);
            end
        end else begin
            if (cur == STRONG_NOT_TAKE) begin
                nxt = STRONG_NOT_TAKE;
            end else begin
                nxt = ctr_state_t'(cur - 2'd1);
            end
        end
        return nxt;
    endfunction

    // Only indirect jumps and conditional branches are trained
    function automatic logic is_trained_type(input ir_type_t t);
        return (t == IR_JALR) || (t == IR_BRANCH);
    endfunction

    // Asynchronous read
    assign rd_entry = entries[rd_index];

    assign clear_entry.ctr    = CLEAR_STATE;
    assign clear_entry.target = 32'd0;

    assign train = resolve.valid && is_trained_type(resolve.ir_type);

    // Next contents of the trained entry
    assign old_entry = entries[wr_index];

    always_comb begin
        new_entry.ctr = next_ctr(old_entry.ctr, resolve.taken);

        // Target kept on a not-taken outcome
        if (resolve.taken) begin
            new_entry.target = resolve.target;
        end else begin
            new_entry.target = old_entry.target;
        end
    end

    // Single write port, clear has priority over training
    always_ff @(posedge clk) begin
        if (!reset) begin
            if (clear_en) begin
                entries[clear_index] <= clear_entry;
            end else if (train) begin
                entries[wr_index] <= new_entry;
            end
        end
    end

endmodule

/* hw/clear_sequencer.sv */
module clear_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic last,
    output logic start,
    output logic clear_en,
    output logic ready
);

    typedef enum logic [1:0] {
        START = 2'd0,
        SWEEP = 2'd1,
        READY = 2'd2
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= START;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;

        case (state)
            // First write of the sweep happens here at index 0
            START: begin
                state_next = SWEEP;
            end

            SWEEP: begin
                if (last) begin
                    state_next = READY;
                end
            end

            READY: begin
                state_next = READY;
            end

            default: begin
                state_next = START;
            end
        endcase

        // A flush restarts the sweep from any state
        if (flush) begin
            state_next = START;
        end
    end

    assign start    = (state == START);
    assign clear_en = (state == START) || (state == SWEEP);
    assign ready    = (state == READY);

endmodule

/* hw/sweep_counter.sv */
module sweep_counter #(
    parameter int NUM_BITS = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                run,
    output logic [NUM_BITS-1:0] index,
    output logic                last
);

    logic [NUM_BITS-1:0] count;

    // Start forces index 0 in the same cycle
    assign index = start ? '0 : count;

    // High on the cycle that writes the final entry
    assign last = run && (&index);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (run) begin
            // Wraps back to zero after the last entry
            count <= index + 1'b1;
        end
    end

endmodule

/* hw/ir_classifier.sv */
module ir_classifier import bpred_pkg::*; (
    input  instr_u      instr,
    input  logic [31:0] pc,
    output ir_type_t    ir_type,
    output logic [31:0] jal_target
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct3_legal;
    logic [31:0] j_offset;

    // Both views place the opcode in the same bits
    assign opcode = instr.j_view.opcode;
    assign funct3 = instr.b_view.funct3;

    // 010 and 011 are reserved branch encodings
    assign funct3_legal = (funct3 != 3'b010) && (funct3 != 3'b011);

    // Sign extended J immediate, bit 0 always zero
    assign j_offset = {
        {11{instr.j_view.imm20}},
        instr.j_view.imm20,
        instr.j_view.imm19_12,
        instr.j_view.imm11,
        instr.j_view.imm10_1,
        1'b0
    };

    assign jal_target = pc + j_offset;

    always_comb begin
        case (opcode)
            OPC_JAL: begin
                ir_type = IR_JAL;
            end

            OPC_JALR: begin
                ir_type = IR_JALR;
            end

            OPC_BRANCH: begin
                if (funct3_legal) begin
                    ir_type = IR_BRANCH;
                end else begin
                    ir_type = IR_OTHER;
                end
            end

            default: begin
                ir_type = IR_OTHER;
            end
        endcase
    end

endmodule

/* hw/bpred_pkg.sv */
package bpred_pkg;

    // RV32I major opcodes of the control transfer instructions
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Control type of a fetched or resolved instruction
    typedef enum logic [3:0] {
        IR_OTHER  = 4'd0,
        IR_JAL    = 4'd1,
        IR_JALR   = 4'd2,
        IR_BRANCH = 4'd3
    } ir_type_t;

    // 2-bit saturating counter, upper bit set means predict taken
    typedef enum logic [1:0] {
        STRONG_NOT_TAKE = 2'b00,
        WEAK_NOT_TAKE   = 2'b01,
        WEAK_TAKE       = 2'b10,
        STRONG_TAKE     = 2'b11
    } ctr_state_t;

    localparam ctr_state_t CLEAR_STATE = WEAK_NOT_TAKE;

    // J-type layout, imm[20|10:1|11|19:12]
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_view_t;

    // B-type layout, imm[12|10:5] and imm[4:1|11]
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_view_t;

    typedef union packed {
        j_view_t j_view;
        b_view_t b_view;
    } instr_u;

    // One table entry, 34 bits
    typedef struct packed {
        ctr_state_t  ctr;
        logic [31:0] target;
    } entry_t;

    // Resolved outcome from the EX stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        ir_type_t    ir_type;
        logic        taken;
        logic [31:0] target;
    } resolve_t;

    // Current fetch from the IF stage
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc4;
        instr_u      instr;
    } fetch_t;

endpackage
